//--- build.f
+incdir+.
aes_ctrl_pkg.sv
aes_ctrl_rail.sv
aes_ctrl_combine.sv
aes_cipher_ctrl.sv
tb_aes_cipher_ctrl.sv

//--- Makefile
# Verilator simulation of the AES cipher control block

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_aes_cipher_ctrl -f build.f -Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim

clean:
	rm -rf obj_dir

//--- tb_aes_model.svh
/*
 * Reference model of the control schedule plus the compare tasks.
 * Included inside the testbench module and reads its DUT signals directly.
 */
`ifndef TB_AES_MODEL_SVH
`define TB_AES_MODEL_SVH

// Expected state of both rails
aes_ctrl_pkg::ctrl_state_e m_state;
int unsigned               m_ctr;
int unsigned               m_lim;
aes_ctrl_pkg::ciph_op_e    m_op;
logic                      m_gen; // Key generation pass

function automatic int unsigned rounds_for(aes_ctrl_pkg::key_len_e len);
  case (len)
    aes_ctrl_pkg::AES_192: return aes_ctrl_pkg::NumRounds192;
    aes_ctrl_pkg::AES_256: return aes_ctrl_pkg::NumRounds256;
    default:               return aes_ctrl_pkg::NumRounds128;
  endcase
endfunction

function automatic aes_ctrl_pkg::sp2v_e to_sp2v(logic b);
  return b ? aes_ctrl_pkg::SP2V_HIGH : aes_ctrl_pkg::SP2V_LOW;
endfunction

task automatic model_reset();
  m_state = aes_ctrl_pkg::CTRL_IDLE;
  m_ctr   = 0;
  m_lim   = aes_ctrl_pkg::NumRounds128;
  m_op    = aes_ctrl_pkg::CIPH_FWD;
  m_gen   = 1'b0;
endtask

// Next state from the inputs of the current cycle
task automatic model_step();
  case (m_state)
    aes_ctrl_pkg::CTRL_IDLE: begin
      if (in_valid_i == aes_ctrl_pkg::SP2V_HIGH) begin
        m_op    = op_i;
        m_gen   = dec_key_gen_i;
        m_lim   = rounds_for(key_len_i);
        m_ctr   = 0;
        m_state = aes_ctrl_pkg::CTRL_INIT;
      end
    end
    aes_ctrl_pkg::CTRL_INIT: begin
      m_ctr   = 1;
      m_state = aes_ctrl_pkg::CTRL_ROUND;
    end
    aes_ctrl_pkg::CTRL_ROUND: begin
      if (m_ctr == m_lim) begin
        m_ctr   = 0;
        m_state = aes_ctrl_pkg::CTRL_FINISH;
      end else begin
        m_ctr++;
      end
    end
    aes_ctrl_pkg::CTRL_FINISH: begin
      if (out_ready_i == aes_ctrl_pkg::SP2V_HIGH) m_state = aes_ctrl_pkg::CTRL_IDLE;
    end
    default: m_ctr = 0;
  endcase
  if (alert_fatal_i) begin
    m_ctr   = 0;
    m_state = aes_ctrl_pkg::CTRL_ERROR;
  end
endtask

////////////////////
// Compare tasks
////////////////////

task automatic check_sp2v(input string name, input aes_ctrl_pkg::sp2v_e got,
                          input aes_ctrl_pkg::sp2v_e exp);
  if (got !== exp) fail_now($sformatf("MISMATCH at %0t: %s is %b, expected %b",
                                      $time, name, got, exp));
endtask

task automatic check_sel(input aes_ctrl_pkg::state_sel_e got_s,
                         input aes_ctrl_pkg::state_sel_e exp_s,
                         input aes_ctrl_pkg::add_rk_sel_e got_a,
                         input aes_ctrl_pkg::add_rk_sel_e exp_a);
  if (got_s !== exp_s || got_a !== exp_a) begin
    fail_now($sformatf("MISMATCH at %0t: state_sel/add_rk_sel %b/%b, expected %b/%b",
                       $time, got_s, got_a, exp_s, exp_a));
  end
endtask

task automatic check_round(input logic [aes_ctrl_pkg::RndCtrWidth-1:0] got_r,
                           input logic [aes_ctrl_pkg::RndCtrWidth-1:0] exp_r,
                           input aes_ctrl_pkg::ciph_op_e got_op,
                           input aes_ctrl_pkg::ciph_op_e exp_op);
  if (got_r !== exp_r || got_op !== exp_op) begin
    fail_now($sformatf("MISMATCH at %0t: round/op %0d/%b, expected %0d/%b",
                       $time, got_r, got_op, exp_r, exp_op));
  end
endtask

task automatic check_alert(input logic got, input logic exp);
  if (got !== exp) fail_now($sformatf("MISMATCH at %0t: alert_o is %b, expected %b",
                                      $time, got, exp));
endtask

task automatic check_outputs();
  logic                      working;
  aes_ctrl_pkg::add_rk_sel_e exp_rk;
  working = (m_state == aes_ctrl_pkg::CTRL_INIT) || (m_state == aes_ctrl_pkg::CTRL_ROUND);
  if (m_state == aes_ctrl_pkg::CTRL_ROUND) begin
    exp_rk = (m_ctr == m_lim) ? aes_ctrl_pkg::ADD_RK_FINAL : aes_ctrl_pkg::ADD_RK_ROUND;
  end else begin
    exp_rk = aes_ctrl_pkg::ADD_RK_INIT;
  end
  check_sp2v("in_ready_o", in_ready_o, to_sp2v(m_state == aes_ctrl_pkg::CTRL_IDLE));
  check_sp2v("out_valid_o", out_valid_o, to_sp2v(m_state == aes_ctrl_pkg::CTRL_FINISH));
  check_sp2v("state_we_o", state_we_o, to_sp2v(working && !m_gen));
  check_sp2v("key_expand_en_o", key_expand_en_o, to_sp2v(working));
  check_sel(state_sel_o, (m_state == aes_ctrl_pkg::CTRL_ROUND) ? aes_ctrl_pkg::STATE_ROUND :
            aes_ctrl_pkg::STATE_INIT, add_rk_sel_o, exp_rk);
  check_round(key_expand_round_o, aes_ctrl_pkg::RndCtrWidth'(m_ctr), key_expand_op_o,
              m_gen ? aes_ctrl_pkg::CIPH_FWD : m_op);
  check_alert(alert_o, m_state == aes_ctrl_pkg::CTRL_ERROR);
endtask

`endif

//--- tb_aes_cipher_ctrl.sv
`timescale 1ns/1ps
/*
 * Testbench for the dual-rail AES cipher control block. Random cipher and key
 * generation passes with back-pressure, then error injection, all checked per cycle.
 */
module tb_aes_cipher_ctrl;

  localparam int unsigned ClkPeriod = 40;
  localparam int unsigned NumTests  = 40;
  localparam int unsigned MaxStall  = 30;           // Out_ready low cycles
  localparam int unsigned Seed      = 32'h3dd3_1418;
  localparam int unsigned WatchdogCycles =
    (NumTests + 2) * (aes_ctrl_pkg::NumRounds256 + MaxStall + 6);

  logic                                 clk_i = 1'b0;
  logic                                 rst_ni;
  aes_ctrl_pkg::sp2v_e                  in_valid_i, in_ready_o, out_valid_o, out_ready_i;
  aes_ctrl_pkg::ciph_op_e               op_i;
  aes_ctrl_pkg::key_len_e               key_len_i;
  logic                                 dec_key_gen_i, alert_fatal_i;
  aes_ctrl_pkg::sp2v_e                  state_we_o, key_expand_en_o;
  aes_ctrl_pkg::state_sel_e             state_sel_o;
  aes_ctrl_pkg::add_rk_sel_e            add_rk_sel_o;
  aes_ctrl_pkg::ciph_op_e               key_expand_op_o;
  logic [aes_ctrl_pkg::RndCtrWidth-1:0] key_expand_round_o;
  logic                                 alert_o;
  aes_ctrl_pkg::sp2v_e                  out_valid_seen; // Taken at the falling edge

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped");
  endtask

  `include "tb_aes_model.svh"

  aes_cipher_ctrl u_aes_cipher_ctrl (
    .clk_i              ( clk_i              ),
    .rst_ni             ( rst_ni             ),
    .in_valid_i         ( in_valid_i         ),
    .in_ready_o         ( in_ready_o         ),
    .out_valid_o        ( out_valid_o        ),
    .out_ready_i        ( out_ready_i        ),
    .op_i               ( op_i               ),
    .key_len_i          ( key_len_i          ),
    .dec_key_gen_i      ( dec_key_gen_i      ),
    .alert_fatal_i      ( alert_fatal_i      ),
    .state_we_o         ( state_we_o         ),
    .key_expand_en_o    ( key_expand_en_o    ),
    .state_sel_o        ( state_sel_o        ),
    .add_rk_sel_o       ( add_rk_sel_o       ),
    .key_expand_op_o    ( key_expand_op_o    ),
    .key_expand_round_o ( key_expand_round_o ),
    .alert_o            ( alert_o            )
  );

  initial begin : clk_gen
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin : watchdog
    #(WatchdogCycles * ClkPeriod);
    fail_now("TIMEOUT: the run did not finish within the expected number of cycles");
  end

  function automatic aes_ctrl_pkg::key_len_e pick_key_len();
    case ($urandom_range(2, 0))
      0:       return aes_ctrl_pkg::AES_128;
      1:       return aes_ctrl_pkg::AES_192;
      default: return aes_ctrl_pkg::AES_256;
    endcase
  endfunction

  function automatic aes_ctrl_pkg::ciph_op_e pick_op();
    return ($urandom_range(1, 0) != 0) ? aes_ctrl_pkg::CIPH_INV : aes_ctrl_pkg::CIPH_FWD;
  endfunction

  // Check at the falling edge, advance the model, end on the rising edge
  task automatic run_cycle();
    @(negedge clk_i);
    out_valid_seen = out_valid_o;
    check_outputs();
    model_step();
    @(posedge clk_i);
  endtask

  task automatic apply_reset();
    model_reset();
    rst_ni        <= 1'b0;
    in_valid_i    <= aes_ctrl_pkg::SP2V_LOW;
    out_ready_i   <= aes_ctrl_pkg::SP2V_LOW;
    alert_fatal_i <= 1'b0;
    repeat (8) run_cycle();
    rst_ni        <= 1'b1;
  endtask

  task automatic run_operation();
    int unsigned stall;
    stall = $urandom_range(MaxStall, 0);
    in_valid_i    <= aes_ctrl_pkg::SP2V_HIGH;
    out_ready_i   <= to_sp2v(stall == 0);
    op_i          <= pick_op();
    key_len_i     <= pick_key_len();
    dec_key_gen_i <= ($urandom_range(3, 0) == 0);
    run_cycle(); // Accept
    in_valid_i    <= aes_ctrl_pkg::SP2V_LOW;
    // Config changes after accept must not matter
    op_i          <= pick_op();
    key_len_i     <= pick_key_len();
    dec_key_gen_i <= ($urandom_range(1, 0) != 0);
    do run_cycle(); while (out_valid_seen != aes_ctrl_pkg::SP2V_HIGH);
    if (stall != 0) begin
      repeat (stall - 1) run_cycle();
      out_ready_i <= aes_ctrl_pkg::SP2V_HIGH;
      run_cycle();
    end
    out_ready_i <= aes_ctrl_pkg::SP2V_LOW;
  endtask

  // Only rail_p sees a request, so the rails split and the combiner flags it
  task automatic inject_bad_valid();
    in_valid_i    <= aes_ctrl_pkg::sp2v_e'(2'b11);
    op_i          <= m_op;
    dec_key_gen_i <= m_gen;
    @(posedge clk_i);
    in_valid_i    <= aes_ctrl_pkg::SP2V_LOW;
    @(posedge clk_i);
    m_state = aes_ctrl_pkg::CTRL_ERROR;
    m_ctr   = 0;
    repeat (6) run_cycle();
  endtask

  task automatic inject_fatal_alert();
    in_valid_i    <= aes_ctrl_pkg::SP2V_HIGH;
    op_i          <= aes_ctrl_pkg::CIPH_INV;
    key_len_i     <= aes_ctrl_pkg::AES_192;
    dec_key_gen_i <= 1'b0;
    run_cycle();
    in_valid_i    <= aes_ctrl_pkg::SP2V_LOW;
    repeat (3) run_cycle();
    alert_fatal_i <= 1'b1; // Mid-round
    run_cycle();
    alert_fatal_i <= 1'b0;
    repeat (6) run_cycle();
  endtask

  initial begin : main
    void'($urandom(Seed));
    op_i          <= aes_ctrl_pkg::CIPH_FWD;
    key_len_i     <= aes_ctrl_pkg::AES_128;
    dec_key_gen_i <= 1'b0;
    apply_reset();
    for (int t = 0; t < NumTests; t++) begin
      repeat ($urandom_range(2, 0)) run_cycle();
      run_operation();
    end
    inject_bad_valid();
    apply_reset();
    inject_fatal_alert();
    apply_reset();
    run_cycle();
    $display("Done: no errors");
    $finish;
  end

endmodule

//--- aes_cipher_ctrl.sv
`timescale 1ns/1ps
/*
 * Top of the AES cipher control block: two redundant rails plus the combiner.
 * Sparse input pairs are split per rail, the merged mismatch flag is fed back.
 */
module aes_cipher_ctrl (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,

  input  aes_ctrl_pkg::sp2v_e                  in_valid_i,
  output aes_ctrl_pkg::sp2v_e                  in_ready_o,
  output aes_ctrl_pkg::sp2v_e                  out_valid_o,
  input  aes_ctrl_pkg::sp2v_e                  out_ready_i,

  input  aes_ctrl_pkg::ciph_op_e               op_i,
  input  aes_ctrl_pkg::key_len_e               key_len_i,
  input  logic                                 dec_key_gen_i,
  input  logic                                 alert_fatal_i,

  output aes_ctrl_pkg::sp2v_e                  state_we_o,
  output aes_ctrl_pkg::sp2v_e                  key_expand_en_o,
  output aes_ctrl_pkg::state_sel_e             state_sel_o,
  output aes_ctrl_pkg::add_rk_sel_e            add_rk_sel_o,
  output aes_ctrl_pkg::ciph_op_e               key_expand_op_o,
  output logic [aes_ctrl_pkg::RndCtrWidth-1:0] key_expand_round_o,
  output logic                                 alert_o
);

  // Rail outputs, index 1 is rail_p and index 0 is rail_n
  logic [aes_ctrl_pkg::Sp2VWidth-1:0]                               mr_in_ready;
  logic [aes_ctrl_pkg::Sp2VWidth-1:0]                               mr_out_valid;
  logic [aes_ctrl_pkg::Sp2VWidth-1:0]                               mr_state_we;
  logic [aes_ctrl_pkg::Sp2VWidth-1:0]                               mr_key_expand_en;
  logic [aes_ctrl_pkg::Sp2VWidth-1:0]                               mr_alert;
  logic [aes_ctrl_pkg::Sp2VWidth-1:0]                               mr_key_gen;
  aes_ctrl_pkg::state_sel_e  [aes_ctrl_pkg::Sp2VWidth-1:0]          mr_state_sel;
  aes_ctrl_pkg::add_rk_sel_e [aes_ctrl_pkg::Sp2VWidth-1:0]          mr_add_rk_sel;
  aes_ctrl_pkg::ciph_op_e    [aes_ctrl_pkg::Sp2VWidth-1:0]          mr_op;
  logic [aes_ctrl_pkg::Sp2VWidth-1:0][aes_ctrl_pkg::RndCtrWidth-1:0] mr_rnd_ctr;
  logic                                                             mismatch;

  aes_ctrl_rail #(
    .ActiveLow ( 1'b0 )
  ) u_rail_p (
    .clk_i           ( clk_i               ),
    .rst_ni          ( rst_ni              ),
    .in_valid_i      ( in_valid_i[1]       ), // Active-high bit
    .in_ready_o      ( mr_in_ready[1]      ),
    .out_valid_o     ( mr_out_valid[1]     ),
    .out_ready_i     ( out_ready_i[1]      ),
    .op_i            ( op_i                ),
    .key_len_i       ( key_len_i           ),
    .dec_key_gen_i   ( dec_key_gen_i       ),
    .alert_fatal_i   ( alert_fatal_i       ),
    .mismatch_i      ( mismatch            ),
    .state_we_o      ( mr_state_we[1]      ),
    .key_expand_en_o ( mr_key_expand_en[1] ),
    .state_sel_o     ( mr_state_sel[1]     ),
    .add_rk_sel_o    ( mr_add_rk_sel[1]    ),
    .rnd_ctr_o       ( mr_rnd_ctr[1]       ),
    .key_gen_o       ( mr_key_gen[1]       ),
    .op_o            ( mr_op[1]            ),
    .alert_o         ( mr_alert[1]         )
  );

  aes_ctrl_rail #(
    .ActiveLow ( 1'b1 )
  ) u_rail_n (
    .clk_i           ( clk_i               ),
    .rst_ni          ( rst_ni              ),
    .in_valid_i      ( in_valid_i[0]       ), // Active-low bit
    .in_ready_o      ( mr_in_ready[0]      ),
    .out_valid_o     ( mr_out_valid[0]     ),
    .out_ready_i     ( out_ready_i[0]      ),
    .op_i            ( op_i                ),
    .key_len_i       ( key_len_i           ),
    .dec_key_gen_i   ( dec_key_gen_i       ),
    .alert_fatal_i   ( alert_fatal_i       ),
    .mismatch_i      ( mismatch            ),
    .state_we_o      ( mr_state_we[0]      ),
    .key_expand_en_o ( mr_key_expand_en[0] ),
    .state_sel_o     ( mr_state_sel[0]     ),
    .add_rk_sel_o    ( mr_add_rk_sel[0]    ),
    .rnd_ctr_o       ( mr_rnd_ctr[0]       ),
    .key_gen_o       ( mr_key_gen[0]       ),
    .op_o            ( mr_op[0]            ),
    .alert_o         ( mr_alert[0]         )
  );

  aes_ctrl_combine u_combine (
    .in_ready_i         ( mr_in_ready        ),
    .out_valid_i        ( mr_out_valid       ),
    .state_we_i         ( mr_state_we        ),
    .key_expand_en_i    ( mr_key_expand_en   ),
    .alert_i            ( mr_alert           ),
    .state_sel_i        ( mr_state_sel       ),
    .add_rk_sel_i       ( mr_add_rk_sel      ),
    .rnd_ctr_i          ( mr_rnd_ctr         ),
    .key_gen_i          ( mr_key_gen         ),
    .op_i               ( mr_op              ),
    .in_ready_o         ( in_ready_o         ),
    .out_valid_o        ( out_valid_o        ),
    .state_we_o         ( state_we_o         ),
    .key_expand_en_o    ( key_expand_en_o    ),
    .state_sel_o        ( state_sel_o        ),
    .add_rk_sel_o       ( add_rk_sel_o       ),
    .key_expand_op_o    ( key_expand_op_o    ),
    .key_expand_round_o ( key_expand_round_o ),
    .alert_o            ( alert_o            ),
    .mismatch_o         ( mismatch           )  // Back to both rails
  );

endmodule

//--- aes_ctrl_combine.sv
`timescale 1ns/1ps
/*
 * Merges the outputs of the two control rails into sparse pairs and selectors.
 * Any disagreement between the rails or any invalid pair raises mismatch_o.
 */
module aes_ctrl_combine (
  // Single-bit rail outputs, bit 1 from rail_p and bit 0 from rail_n
  input  logic [aes_ctrl_pkg::Sp2VWidth-1:0]                               in_ready_i,
  input  logic [aes_ctrl_pkg::Sp2VWidth-1:0]                               out_valid_i,
  input  logic [aes_ctrl_pkg::Sp2VWidth-1:0]                               state_we_i,
  input  logic [aes_ctrl_pkg::Sp2VWidth-1:0]                               key_expand_en_i,
  input  logic [aes_ctrl_pkg::Sp2VWidth-1:0]                               alert_i,

  // Per-rail multi-bit values
  input  aes_ctrl_pkg::state_sel_e  [aes_ctrl_pkg::Sp2VWidth-1:0]          state_sel_i,
  input  aes_ctrl_pkg::add_rk_sel_e [aes_ctrl_pkg::Sp2VWidth-1:0]          add_rk_sel_i,
  input  logic [aes_ctrl_pkg::Sp2VWidth-1:0][aes_ctrl_pkg::RndCtrWidth-1:0] rnd_ctr_i,
  input  logic [aes_ctrl_pkg::Sp2VWidth-1:0]                               key_gen_i,
  input  aes_ctrl_pkg::ciph_op_e    [aes_ctrl_pkg::Sp2VWidth-1:0]          op_i,

  // Merged outputs
  output aes_ctrl_pkg::sp2v_e                                              in_ready_o,
  output aes_ctrl_pkg::sp2v_e                                              out_valid_o,
  output aes_ctrl_pkg::sp2v_e                                              state_we_o,
  output aes_ctrl_pkg::sp2v_e                                              key_expand_en_o,
  output aes_ctrl_pkg::state_sel_e                                         state_sel_o,
  output aes_ctrl_pkg::add_rk_sel_e                                        add_rk_sel_o,
  output aes_ctrl_pkg::ciph_op_e                                           key_expand_op_o,
  output logic [aes_ctrl_pkg::RndCtrWidth-1:0]                             key_expand_round_o,
  output logic                                                             alert_o,
  output logic                                                             mismatch_o
);

  logic                   key_gen;
  aes_ctrl_pkg::ciph_op_e op;
  logic                   rail_err;  // Multi-bit values disagree
  logic                   sp_err;    // Some pair is 00 or 11

  function automatic logic sp2v_bad(aes_ctrl_pkg::sp2v_e v);
    return !(v inside {aes_ctrl_pkg::SP2V_HIGH, aes_ctrl_pkg::SP2V_LOW});
  endfunction

  // Each rail contributes its own bit of the pair
  assign in_ready_o      = aes_ctrl_pkg::sp2v_e'(in_ready_i);
  assign out_valid_o     = aes_ctrl_pkg::sp2v_e'(out_valid_i);
  assign state_we_o      = aes_ctrl_pkg::sp2v_e'(state_we_i);
  assign key_expand_en_o = aes_ctrl_pkg::sp2v_e'(key_expand_en_i);

  ////////////////////
  // OR-combine
  ////////////////////

  // Equal rail values pass unchanged, unequal ones get flagged below
  always_comb begin : merge_rails
    state_sel_o        = aes_ctrl_pkg::state_sel_e'('0);
    add_rk_sel_o       = aes_ctrl_pkg::add_rk_sel_e'('0);
    key_expand_round_o = '0;
    key_gen            = 1'b0;
    op                 = aes_ctrl_pkg::ciph_op_e'('0);
    rail_err           = 1'b0;

    for (int i = 0; i < aes_ctrl_pkg::Sp2VWidth; i++) begin
      state_sel_o        = aes_ctrl_pkg::state_sel_e'(state_sel_o | state_sel_i[i]);
      add_rk_sel_o       = aes_ctrl_pkg::add_rk_sel_e'(add_rk_sel_o | add_rk_sel_i[i]);
      key_expand_round_o = key_expand_round_o | rnd_ctr_i[i];
      key_gen            = key_gen | key_gen_i[i];
      op                 = aes_ctrl_pkg::ciph_op_e'(op | op_i[i]);
    end

    for (int i = 0; i < aes_ctrl_pkg::Sp2VWidth; i++) begin
      if (state_sel_o        != state_sel_i[i]  ||
          add_rk_sel_o       != add_rk_sel_i[i] ||
          key_expand_round_o != rnd_ctr_i[i]    ||
          key_gen            != key_gen_i[i]    ||
          op                 != op_i[i]) begin
        rail_err = 1'b1;
      end
    end
  end

  assign sp_err = sp2v_bad(in_ready_o) | sp2v_bad(out_valid_o) |
                  sp2v_bad(state_we_o) | sp2v_bad(key_expand_en_o);

  assign alert_o    = |alert_i;
  assign mismatch_o = rail_err | sp_err | (^alert_i); // Alert bits differ

  // Decryption key generation always runs the forward key schedule
  assign key_expand_op_o = key_gen ? aes_ctrl_pkg::CIPH_FWD : op;

endmodule

//--- aes_ctrl_rail.sv
`timescale 1ns/1ps
/*
 * Single-rail round control FSM. Two copies run in lockstep, one per bit of
 * every sparse pair; ActiveLow flips the polarity of the handshake and enable bits.
 */
module aes_ctrl_rail #(
  parameter bit ActiveLow = 1'b0
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,

  // Handshakes, this rail's bit only
  input  logic                                 in_valid_i,
  output logic                                 in_ready_o,
  output logic                                 out_valid_o,
  input  logic                                 out_ready_i,

  // Operation config, sampled on accept
  input  aes_ctrl_pkg::ciph_op_e               op_i,
  input  aes_ctrl_pkg::key_len_e               key_len_i,
  input  logic                                 dec_key_gen_i,

  // Error sources
  input  logic                                 alert_fatal_i,
  input  logic                                 mismatch_i,

  // Data path and key expand control
  output logic                                 state_we_o,
  output logic                                 key_expand_en_o,
  output aes_ctrl_pkg::state_sel_e             state_sel_o,
  output aes_ctrl_pkg::add_rk_sel_e            add_rk_sel_o,
  output logic [aes_ctrl_pkg::RndCtrWidth-1:0] rnd_ctr_o,
  output logic                                 key_gen_o,
  output aes_ctrl_pkg::ciph_op_e               op_o,
  output logic                                 alert_o
);

  aes_ctrl_pkg::ctrl_state_e                state_d, state_q;
  logic [aes_ctrl_pkg::RndCtrWidth-1:0]     rnd_ctr_d, rnd_ctr_q;
  logic [aes_ctrl_pkg::RndCtrWidth-1:0]     rnd_lim_d, rnd_lim_q;
  logic [aes_ctrl_pkg::RndCtrWidth-1:0]     rnd_lim_new;
  aes_ctrl_pkg::ciph_op_e                   op_d, op_q;
  logic                                     key_gen_d, key_gen_q;

  // Logical (active-high) view of the handshake and enable bits
  logic in_valid, out_ready;
  logic in_ready, out_valid, state_we, key_expand_en;

  assign in_valid  = in_valid_i ^ ActiveLow;
  assign out_ready = out_ready_i ^ ActiveLow;

  // Last round index for the requested key length
  always_comb begin : rnd_lim_sel
    case (key_len_i)
      aes_ctrl_pkg::AES_128: rnd_lim_new = aes_ctrl_pkg::RndCtrWidth'(aes_ctrl_pkg::NumRounds128);
      aes_ctrl_pkg::AES_192: rnd_lim_new = aes_ctrl_pkg::RndCtrWidth'(aes_ctrl_pkg::NumRounds192);
      aes_ctrl_pkg::AES_256: rnd_lim_new = aes_ctrl_pkg::RndCtrWidth'(aes_ctrl_pkg::NumRounds256);
      default:               rnd_lim_new = aes_ctrl_pkg::RndCtrWidth'(aes_ctrl_pkg::NumRounds128);
    endcase
  end

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin : fsm_comb
    state_d       = state_q;
    rnd_ctr_d     = rnd_ctr_q;
    rnd_lim_d     = rnd_lim_q;
    op_d          = op_q;
    key_gen_d     = key_gen_q;

    in_ready      = 1'b0;
    out_valid     = 1'b0;
    state_we      = 1'b0;
    key_expand_en = 1'b0;
    state_sel_o   = aes_ctrl_pkg::STATE_INIT;
    add_rk_sel_o  = aes_ctrl_pkg::ADD_RK_INIT;
    alert_o       = 1'b0;

    unique case (state_q)
      aes_ctrl_pkg::CTRL_IDLE: begin
        in_ready = 1'b1;
        if (in_valid) begin
          // Latch the whole pass description on accept
          op_d      = op_i;
          key_gen_d = dec_key_gen_i;
          rnd_lim_d = rnd_lim_new;
          rnd_ctr_d = '0;
          state_d   = aes_ctrl_pkg::CTRL_INIT;
        end
      end

      aes_ctrl_pkg::CTRL_INIT: begin
        // Initial key addition, round 0
        key_expand_en = 1'b1;
        state_we      = ~key_gen_q;       // Key generation leaves the state alone
        state_sel_o   = aes_ctrl_pkg::STATE_INIT;
        add_rk_sel_o  = aes_ctrl_pkg::ADD_RK_INIT;
        rnd_ctr_d     = rnd_ctr_q + aes_ctrl_pkg::RndCtrWidth'(1);
        state_d       = aes_ctrl_pkg::CTRL_ROUND;
      end

      aes_ctrl_pkg::CTRL_ROUND: begin
        key_expand_en = 1'b1;
        state_we      = ~key_gen_q;
        state_sel_o   = aes_ctrl_pkg::STATE_ROUND;
        if (rnd_ctr_q == rnd_lim_q) begin
          add_rk_sel_o = aes_ctrl_pkg::ADD_RK_FINAL; // Last round skips MixColumns
          rnd_ctr_d    = '0;
          state_d      = aes_ctrl_pkg::CTRL_FINISH;
        end else begin
          add_rk_sel_o = aes_ctrl_pkg::ADD_RK_ROUND;
          rnd_ctr_d    = rnd_ctr_q + aes_ctrl_pkg::RndCtrWidth'(1);
        end
      end

      aes_ctrl_pkg::CTRL_FINISH: begin
        out_valid = 1'b1;
        if (out_ready) begin
          state_d = aes_ctrl_pkg::CTRL_IDLE;
        end
      end

      aes_ctrl_pkg::CTRL_ERROR: begin
        // Terminal until reset
        alert_o   = 1'b1;
        rnd_ctr_d = '0;
      end

      default: begin
        // Corrupted state encoding
        rnd_ctr_d = '0;
        state_d   = aes_ctrl_pkg::CTRL_ERROR;
      end
    endcase

    // Errors override any transition
    if (alert_fatal_i || mismatch_i) begin
      rnd_ctr_d = '0;
      state_d   = aes_ctrl_pkg::CTRL_ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_regs
    if (!rst_ni) begin
      state_q   <= aes_ctrl_pkg::CTRL_IDLE;
      rnd_ctr_q <= '0;
      rnd_lim_q <= aes_ctrl_pkg::RndCtrWidth'(aes_ctrl_pkg::NumRounds128);
      op_q      <= aes_ctrl_pkg::CIPH_FWD;
      key_gen_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      rnd_ctr_q <= rnd_ctr_d;
      rnd_lim_q <= rnd_lim_d;
      op_q      <= op_d;
      key_gen_q <= key_gen_d;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign in_ready_o      = in_ready ^ ActiveLow;
  assign out_valid_o     = out_valid ^ ActiveLow;
  assign state_we_o      = state_we ^ ActiveLow;
  assign key_expand_en_o = key_expand_en ^ ActiveLow;

  assign rnd_ctr_o = rnd_ctr_q;
  assign key_gen_o = key_gen_q;
  assign op_o      = op_q;

endmodule

//--- aes_ctrl_pkg.sv
/*
 * Shared types and constants for the dual-rail AES cipher control block.
 * Referenced through scoped names by the rails, the combiner and the top level.
 */
package aes_ctrl_pkg;

  ////////////////////
  // Sparse booleans
  ////////////////////

  // Bit 1 belongs to the active-high rail, bit 0 to the active-low rail
  typedef enum logic [1:0] {
    SP2V_HIGH = 2'b10,
    SP2V_LOW  = 2'b01
  } sp2v_e;

  localparam int unsigned Sp2VWidth = 2; // One bit per rail

  ////////////////////
  // Operation
  ////////////////////

  typedef enum logic [1:0] {
    CIPH_FWD = 2'b01,
    CIPH_INV = 2'b10
  } ciph_op_e;

  typedef enum logic [2:0] {
    AES_128 = 3'b001,
    AES_192 = 3'b010,
    AES_256 = 3'b100
  } key_len_e;

  localparam int unsigned NumRounds128 = 10;
  localparam int unsigned NumRounds192 = 12;
  localparam int unsigned NumRounds256 = 14;

  localparam int unsigned RndCtrWidth = 4; // Holds up to NumRounds256

  ////////////////////
  // Data path selectors
  ////////////////////

  // Codes differ in two bits so a single flip never lands on another code
  typedef enum logic [2:0] {
    STATE_INIT  = 3'b011,
    STATE_ROUND = 3'b101
  } state_sel_e;

  typedef enum logic [2:0] {
    ADD_RK_INIT  = 3'b011,
    ADD_RK_ROUND = 3'b101,
    ADD_RK_FINAL = 3'b110
  } add_rk_sel_e;

  // Rail FSM states, sparse as well
  typedef enum logic [4:0] {
    CTRL_IDLE   = 5'b01001,
    CTRL_INIT   = 5'b10011,
    CTRL_ROUND  = 5'b11100,
    CTRL_FINISH = 5'b00110,
    CTRL_ERROR  = 5'b10101
  } ctrl_state_e;

endpackage
